// ==== include/wisc_settings.svh ====
`ifndef WISC_SETTINGS_SVH
`define WISC_SETTINGS_SVH

// Core datapath sizing

`define WISC_WORD_WIDTH 16  // Data, address and instruction width

`define WISC_REG_COUNT 8  // R0 to R7, R7 doubles as link register

// Data memory holds words, the byte address drops bit 0
`define WISC_DMEM_WORDS 256

`endif

// ==== design/wiscPkg.sv ====
`include "wisc_settings.svh"

package wiscPkg;

    typedef logic [`WISC_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`WISC_REG_COUNT)-1:0] regAddr_t;
    typedef logic [4:0] opcode_t;  // instr[15:11]
    typedef logic [2:0] aluOpr_t;

    // ALU operation classes
    localparam aluOpr_t oprAddLogic = 3'd0;  // add, sub, xor, andn
    localparam aluOpr_t oprShift = 3'd1;  // rol, sll, ror, srl
    localparam aluOpr_t oprCompare = 3'd2;  // seq, slt, sle, sco
    localparam aluOpr_t oprMemAddr = 3'd3;  // Rs + imm5
    localparam aluOpr_t oprBranch = 3'd4;  // Pass A
    localparam aluOpr_t oprBitRev = 3'd5;
    localparam aluOpr_t oprByteIns = 3'd6;  // slbi and lbi

    typedef struct packed {
        logic [1:0] regDst;  // 00 [7:5], 01 [10:8], 10 [4:2], 11 R7
        logic [1:0] regSrc;  // 00 PC+2, 01 mem, 10 ALU, 11 flag
        logic       regWrt;
        logic       memWrt;
        logic       zeroExt;
        logic [1:0] bSrc;  // 00 Rt, 01 imm5, 10 imm8
        logic       immSrc;  // Jump uses imm8 off Rs
        aluOpr_t    aluOpr;
        logic [1:0] aluFunct;
        logic       invA;
        logic       invB;
        logic       cin;
        logic       aluJmp;
        logic       branch;
        logic [1:0] branchCond;  // 00 eqz, 01 nez, 10 ltz, 11 gez
        logic       halt;
        logic       err;
    } ctrlBundle_t;

endpackage

// ==== design/control.sv ====
`timescale 1ns/1ns

module control (
    input  wiscPkg::word_t       instr,
    output wiscPkg::ctrlBundle_t ctrl
);
    import wiscPkg::*;

    opcode_t opcode;
    logic [1:0] funct;
    logic [1:0] aluSel;  // Funct only in the two R-format groups

    assign opcode = instr[15:11];
    assign funct = instr[1:0];
    assign aluSel = (opcode[4:3] == 2'b11) ? funct : opcode[1:0];

    always_comb begin
        ctrl = '0;  // NOP bundle
        case (opcode)
            5'b00000: ctrl.halt = 1'b1;  // HALT
            5'b00001: begin  // NOP
            end
            5'b00010, 5'b00011: ctrl.err = 1'b1;  // siic and RTI not supported
            5'b00100: begin  // J
                ctrl.aluJmp = 1'b1;
            end
            5'b00101: begin  // JR
                ctrl.aluJmp = 1'b1;
                ctrl.immSrc = 1'b1;
            end
            5'b00110, 5'b00111: begin  // JAL, JALR
                ctrl.aluJmp = 1'b1;
                ctrl.immSrc = opcode[0];
                ctrl.regWrt = 1'b1;
                ctrl.regDst = 2'b11;
                ctrl.regSrc = 2'b00;
            end
            5'b01000, 5'b01001, 5'b01010, 5'b01011: begin  // ADDI, SUBI, XORI, ANDNI
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b00;
                ctrl.bSrc = 2'b01;
                ctrl.zeroExt = opcode[1];  // XORI, ANDNI
                ctrl.aluOpr = oprAddLogic;
                ctrl.aluFunct = aluSel;
                ctrl.invA = (aluSel == 2'b01);
                ctrl.cin = (aluSel == 2'b01);
                ctrl.invB = (aluSel == 2'b11);
            end
            5'b01100, 5'b01101, 5'b01110, 5'b01111: begin  // BEQZ, BNEZ, BLTZ, BGEZ
                ctrl.branch = 1'b1;
                ctrl.branchCond = opcode[1:0];
                ctrl.aluOpr = oprBranch;
            end
            5'b10000, 5'b10001, 5'b10011: begin  // ST, LD, STU
                ctrl.bSrc = 2'b01;
                ctrl.aluOpr = oprMemAddr;
                ctrl.memWrt = ~opcode[0] | opcode[1];
                ctrl.regWrt = opcode[0];
                ctrl.regSrc = opcode[1] ? 2'b10 : 2'b01;  // STU writes back the address
                ctrl.regDst = opcode[1] ? 2'b01 : 2'b00;
            end
            5'b10010: begin  // SLBI
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b01;
                ctrl.bSrc = 2'b10;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOpr = oprByteIns;
                ctrl.aluFunct = 2'b00;
            end
            5'b10100, 5'b10101, 5'b10110, 5'b10111: begin  // ROLI, SLLI, RORI, SRLI
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b00;
                ctrl.bSrc = 2'b01;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOpr = oprShift;
                ctrl.aluFunct = aluSel;
            end
            5'b11000: begin  // LBI
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b01;
                ctrl.bSrc = 2'b10;
                ctrl.aluOpr = oprByteIns;
                ctrl.aluFunct = 2'b01;  // Pass sign-extended imm8
            end
            5'b11001: begin  // BTR
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b10;
                ctrl.aluOpr = oprBitRev;
            end
            5'b11010: begin  // ROL, SLL, ROR, SRL
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b10;
                ctrl.aluOpr = oprShift;
                ctrl.aluFunct = aluSel;
            end
            5'b11011: begin  // ADD, SUB, XOR, ANDN
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b10;
                ctrl.regDst = 2'b10;
                ctrl.aluOpr = oprAddLogic;
                ctrl.aluFunct = aluSel;
                ctrl.invA = (aluSel == 2'b01);
                ctrl.cin = (aluSel == 2'b01);
                ctrl.invB = (aluSel == 2'b11);
            end
            5'b11100, 5'b11101, 5'b11110, 5'b11111: begin  // SEQ, SLT, SLE, SCO
                ctrl.regWrt = 1'b1;
                ctrl.regSrc = 2'b11;
                ctrl.regDst = 2'b10;
                ctrl.aluOpr = oprCompare;
                ctrl.aluFunct = opcode[1:0];
            end
            default: ctrl.err = 1'b1;
        endcase
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns
`include "wisc_settings.svh"

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  wiscPkg::regAddr_t rdAddrA,
    input  wiscPkg::regAddr_t rdAddrB,
    input  logic              wrEn,
    input  wiscPkg::regAddr_t wrAddr,
    input  wiscPkg::word_t    wrData,
    output wiscPkg::word_t    rdDataA,
    output wiscPkg::word_t    rdDataB
);
    import wiscPkg::*;

    word_t regs [`WISC_REG_COUNT];

    // Reads see the value from before this edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (rstN && wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns
`include "wisc_settings.svh"

module alu (
    input  wiscPkg::word_t   a,
    input  wiscPkg::word_t   b,
    input  wiscPkg::aluOpr_t aluOpr,
    input  logic [1:0]       aluFunct,
    input  logic             invA,
    input  logic             invB,
    input  logic             cin,
    output wiscPkg::word_t   result,
    output logic             flag
);
    import wiscPkg::*;

    word_t opA;
    word_t opB;
    word_t sum;
    word_t reversed;
    logic carry;
    logic [3:0] shAmt;
    logic [2*`WISC_WORD_WIDTH-1:0] rolWide;
    logic [2*`WISC_WORD_WIDTH-1:0] rorWide;

    assign opA = invA ? ~a : a;
    assign opB = invB ? ~b : b;
    assign {carry, sum} = opA + opB + cin;

    assign shAmt = b[3:0];
    assign rolWide = {a, a} << shAmt;
    assign rorWide = {a, a} >> shAmt;

    always_comb begin
        for (int i = 0; i < `WISC_WORD_WIDTH; i++) begin
            reversed[i] = a[`WISC_WORD_WIDTH-1-i];
        end
    end

    always_comb begin
        result = sum;
        flag = 1'b0;
        case (aluOpr)
            oprAddLogic: begin
                case (aluFunct)
                    2'b10: result = opA ^ opB;
                    2'b11: result = opA & opB;  // B already inverted
                    default: result = sum;  // Add, reversed subtract
                endcase
            end
            oprShift: begin
                case (aluFunct)
                    2'b00: result = rolWide[2*`WISC_WORD_WIDTH-1:`WISC_WORD_WIDTH];
                    2'b01: result = a << shAmt;
                    2'b10: result = rorWide[`WISC_WORD_WIDTH-1:0];
                    default: result = a >> shAmt;
                endcase
            end
            oprCompare: begin
                case (aluFunct)
                    2'b00: flag = (a == b);
                    2'b01: flag = ($signed(a) < $signed(b));
                    2'b10: flag = ($signed(a) <= $signed(b));
                    default: flag = carry;  // SCO
                endcase
            end
            oprMemAddr: result = sum;
            oprBranch: result = a;
            oprBitRev: result = reversed;
            oprByteIns: result = aluFunct[0] ? b : ({a[7:0], 8'h00} | b);
            default: result = sum;
        endcase
    end

endmodule

// ==== design/branchUnit.sv ====
`timescale 1ns/1ns
`include "wisc_settings.svh"

module branchUnit (
    input  wiscPkg::word_t       pc,
    input  wiscPkg::word_t       rsData,
    input  wiscPkg::word_t       instr,
    input  wiscPkg::ctrlBundle_t ctrl,
    output wiscPkg::word_t       nextPc,
    output logic                 taken
);
    import wiscPkg::*;

    word_t pcPlus2;
    word_t imm8Ext;
    word_t disp11Ext;
    logic condMet;
    logic rsNeg;

    assign pcPlus2 = pc + word_t'(2);
    assign imm8Ext = {{8{instr[7]}}, instr[7:0]};
    assign disp11Ext = {{5{instr[10]}}, instr[10:0]};
    assign rsNeg = rsData[`WISC_WORD_WIDTH-1];

    always_comb begin
        case (ctrl.branchCond)
            2'b00: condMet = (rsData == '0);
            2'b01: condMet = (rsData != '0);
            2'b10: condMet = rsNeg;
            default: condMet = ~rsNeg;
        endcase
    end

    assign taken = ctrl.aluJmp | (ctrl.branch & condMet);

    always_comb begin
        if (ctrl.aluJmp && ctrl.immSrc) begin
            nextPc = rsData + imm8Ext;  // JR, JALR
        end else if (ctrl.aluJmp) begin
            nextPc = pcPlus2 + disp11Ext;
        end else if (taken) begin
            nextPc = pcPlus2 + imm8Ext;
        end else begin
            nextPc = pcPlus2;
        end
    end

endmodule

// ==== design/dataMem.sv ====
`timescale 1ns/1ns
`include "wisc_settings.svh"

module dataMem (
    input  logic           clk,
    input  wiscPkg::word_t addr,
    input  logic           wrEn,
    input  wiscPkg::word_t wrData,
    output wiscPkg::word_t rdData
);
    import wiscPkg::*;

    localparam int addrBits = $clog2(`WISC_DMEM_WORDS);

    word_t mem [`WISC_DMEM_WORDS];
    logic [addrBits-1:0] wordIdx;

    // Byte address, upper bits wrap
    assign wordIdx = addr[addrBits:1];

    assign rdData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

endmodule

// ==== design/wiscCore.sv ====
`timescale 1ns/1ns
`include "wisc_settings.svh"

module wiscCore (
    input  logic              clk,
    input  logic              rstN,
    input  wiscPkg::word_t    instr,
    output wiscPkg::word_t    pc,
    output logic              regWrtEn,
    output wiscPkg::regAddr_t regWrtAddr,
    output wiscPkg::word_t    regWrtData,
    output logic              memWrtEn,
    output wiscPkg::word_t    memAddr,
    output wiscPkg::word_t    memWrtData,
    output logic              halted,
    output logic              err
);
    import wiscPkg::*;

    ctrlBundle_t ctrl;
    word_t rdDataA;
    word_t rdDataB;
    word_t imm5Ext;
    word_t imm8Ext;
    word_t opB;
    word_t aluResult;
    word_t memRdData;
    word_t nextPc;
    word_t pcPlus2;
    logic aluFlag;
    logic active;

    control uControl (.instr(instr), .ctrl(ctrl));

    regFile uRegFile (
        .clk(clk), .rstN(rstN),
        .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),
        .wrEn(regWrtEn), .wrAddr(regWrtAddr), .wrData(regWrtData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    assign imm5Ext = ctrl.zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
    assign imm8Ext = ctrl.zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};

    always_comb begin
        case (ctrl.bSrc)
            2'b01: opB = imm5Ext;
            2'b10: opB = imm8Ext;
            default: opB = rdDataB;  // Rt
        endcase
    end

    alu uAlu (
        .a(rdDataA), .b(opB), .aluOpr(ctrl.aluOpr), .aluFunct(ctrl.aluFunct),
        .invA(ctrl.invA), .invB(ctrl.invB), .cin(ctrl.cin),
        .result(aluResult), .flag(aluFlag)
    );

    branchUnit uBranch (
        .pc(pc), .rsData(rdDataA), .instr(instr), .ctrl(ctrl),
        .nextPc(nextPc), .taken()
    );

    dataMem uDataMem (
        .clk(clk), .addr(aluResult), .wrEn(memWrtEn),
        .wrData(rdDataB), .rdData(memRdData)
    );

    assign pcPlus2 = pc + word_t'(2);  // Link value
    assign active = rstN & ~halted;
    assign regWrtEn = ctrl.regWrt & active;
    assign memWrtEn = ctrl.memWrt & active;
    assign memAddr = aluResult;
    assign memWrtData = rdDataB;  // Rd field of ST and STU

    always_comb begin
        case (ctrl.regDst)
            2'b00: regWrtAddr = instr[7:5];
            2'b01: regWrtAddr = instr[10:8];
            2'b10: regWrtAddr = instr[4:2];
            default: regWrtAddr = regAddr_t'(`WISC_REG_COUNT - 1);  // R7
        endcase
        case (ctrl.regSrc)
            2'b00: regWrtData = pcPlus2;
            2'b01: regWrtData = memRdData;
            2'b10: regWrtData = aluResult;
            default: regWrtData = word_t'(aluFlag);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            halted <= 1'b0;
            err <= 1'b0;
        end else if (!halted) begin
            if (ctrl.halt || ctrl.err) begin
                halted <= 1'b1;  // PC stays on the stopping instruction
            end else begin
                pc <= nextPc;
            end
            if (ctrl.err) begin
                err <= 1'b1;
            end
        end
    end

endmodule

// ==== verification/wiscCoreTb.sv ====
`timescale 1ns/1ns
`include "wisc_settings.svh"

module wiscCoreTb;
    import wiscPkg::*;

    typedef struct packed {
        word_t instr;
        logic  skip;  // Must never be fetched
    } progEntry_t;

    localparam word_t nopWord = 16'h0800;
    localparam word_t haltWord = 16'h0000;
    localparam word_t writeProbeWord = 16'h9820;  // STU that writes a register and memory

    logic clk;
    logic rstN;
    word_t instr;
    word_t pc;
    logic regWrtEn;
    regAddr_t regWrtAddr;
    word_t regWrtData;
    logic memWrtEn;
    word_t memAddr;
    word_t memWrtData;
    logic halted;
    logic err;

    progEntry_t prog[$];
    progEntry_t trapProg[$];
    bit trapPhase;
    integer seed;
    integer rnd;
    int mismatches;
    int otherErrors;
    int cycleCount;
    int cycleLimit;

    // Reference model state
    word_t modelRegs [`WISC_REG_COUNT];
    word_t modelMem [`WISC_DMEM_WORDS];
    word_t modelPc;
    logic modelHalted;
    logic modelErr;

    logic expRegEn;
    regAddr_t expRegAddr;
    word_t expRegData;
    logic expMemEn;
    word_t expMemAddr;
    word_t expMemData;
    word_t expNextPc;
    logic expHalt;
    logic expErr;

    wiscCore u_dut (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
        .regWrtEn(regWrtEn), .regWrtAddr(regWrtAddr), .regWrtData(regWrtData),
        .memWrtEn(memWrtEn), .memAddr(memAddr), .memWrtData(memWrtData),
        .halted(halted), .err(err)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout at %0t: the program did not finish within %0d cycles",
                     $time, cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic word_t encI1(input logic [4:0] op, input regAddr_t rs,
                                    input regAddr_t rd, input logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic word_t encR(input logic [4:0] op, input regAddr_t rs,
                                   input regAddr_t rt, input regAddr_t rd,
                                   input logic [1:0] funct);
        return {op, rs, rt, rd, funct};
    endfunction

    function automatic word_t encI2(input logic [4:0] op, input regAddr_t rs,
                                    input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic word_t rotl(input word_t v, input logic [3:0] n);
        return (v << n) | (v >> (16 - n));
    endfunction

    function automatic word_t rotr(input word_t v, input logic [3:0] n);
        return (v >> n) | (v << (16 - n));
    endfunction

    function automatic word_t mirror(input word_t v);
        word_t r;
        for (int i = 0; i < 16; i++) begin
            r[15-i] = v[i];
        end
        return r;
    endfunction

    task automatic addEntry(input word_t ins, input logic skip);
        prog.push_back('{instr: ins, skip: skip});
    endtask

    task automatic setWrite(input regAddr_t dst, input word_t val);
        expRegEn = 1'b1;
        expRegAddr = dst;
        expRegData = val;
    endtask

    // ISA reference for the instruction presented this cycle
    task automatic computeExpected(input word_t ins);
        logic [4:0] op;
        regAddr_t rs;
        regAddr_t rt;
        word_t a;
        word_t b;
        word_t imm5s;
        word_t imm5z;
        word_t imm8s;
        word_t pcNext;
        logic [16:0] wide;
        op = ins[15:11];
        rs = ins[10:8];
        rt = ins[7:5];
        a = modelRegs[rs];
        b = modelRegs[rt];
        imm5s = {{11{ins[4]}}, ins[4:0]};
        imm5z = {11'b0, ins[4:0]};
        imm8s = {{8{ins[7]}}, ins[7:0]};
        pcNext = modelPc + 16'd2;
        expRegEn = 1'b0;
        expMemEn = 1'b0;
        expHalt = 1'b0;
        expErr = 1'b0;
        expNextPc = modelPc;
        if (modelHalted) begin
            return;
        end
        case (op)
            5'd0: expHalt = 1'b1;
            5'd1: ;
            5'd4: pcNext = pcNext + {{5{ins[10]}}, ins[10:0]};
            5'd5: pcNext = a + imm8s;
            5'd6: begin
                setWrite(3'd7, pcNext);
                pcNext = pcNext + {{5{ins[10]}}, ins[10:0]};
            end
            5'd7: begin
                setWrite(3'd7, pcNext);
                pcNext = a + imm8s;
            end
            5'd8: setWrite(rt, a + imm5s);
            5'd9: setWrite(rt, imm5s - a);
            5'd10: setWrite(rt, a ^ imm5z);
            5'd11: setWrite(rt, a & ~imm5z);
            5'd12, 5'd13, 5'd14, 5'd15: begin
                if ((op == 5'd12 && a == 0) || (op == 5'd13 && a != 0) ||
                    (op == 5'd14 && a[15]) || (op == 5'd15 && !a[15])) begin
                    pcNext = pcNext + imm8s;
                end
            end
            5'd16, 5'd19: begin
                expMemEn = 1'b1;
                expMemAddr = a + imm5s;
                expMemData = b;
                if (op == 5'd19) begin
                    setWrite(rs, a + imm5s);
                end
            end
            5'd17: setWrite(rt, modelMem[((a + imm5s) >> 1) % `WISC_DMEM_WORDS]);
            5'd18: setWrite(rs, (a << 8) | {8'b0, ins[7:0]});
            5'd20: setWrite(rt, rotl(a, imm5z[3:0]));
            5'd21: setWrite(rt, a << imm5z[3:0]);
            5'd22: setWrite(rt, rotr(a, imm5z[3:0]));
            5'd23: setWrite(rt, a >> imm5z[3:0]);
            5'd24: setWrite(rs, imm8s);
            5'd25: setWrite(ins[4:2], mirror(a));
            5'd26: begin
                case (ins[1:0])
                    2'd0: setWrite(ins[4:2], rotl(a, b[3:0]));
                    2'd1: setWrite(ins[4:2], a << b[3:0]);
                    2'd2: setWrite(ins[4:2], rotr(a, b[3:0]));
                    default: setWrite(ins[4:2], a >> b[3:0]);
                endcase
            end
            5'd27: begin
                case (ins[1:0])
                    2'd0: setWrite(ins[4:2], a + b);
                    2'd1: setWrite(ins[4:2], b - a);
                    2'd2: setWrite(ins[4:2], a ^ b);
                    default: setWrite(ins[4:2], a & ~b);
                endcase
            end
            5'd28: setWrite(ins[4:2], word_t'(a == b));
            5'd29: setWrite(ins[4:2], word_t'($signed(a) < $signed(b)));
            5'd30: setWrite(ins[4:2], word_t'($signed(a) <= $signed(b)));
            5'd31: begin
                wide = {1'b0, a} + {1'b0, b};
                setWrite(ins[4:2], word_t'(wide[16]));
            end
            default: expErr = 1'b1;  // siic, RTI and undefined
        endcase
        if (!expHalt && !expErr) begin
            expNextPc = pcNext;
        end
    endtask

    task automatic commitModel();
        if (expRegEn) begin
            modelRegs[expRegAddr] = expRegData;
        end
        if (expMemEn) begin
            modelMem[(expMemAddr >> 1) % `WISC_DMEM_WORDS] = expMemData;
        end
        if (expHalt || expErr) begin
            modelHalted = 1'b1;
        end
        modelErr = modelErr | expErr;
        modelPc = expNextPc;
    endtask

    task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
        if (actVal !== expVal) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expVal, actVal);
            mismatches++;
        end
    endtask

    task automatic fetchInstr();
        progEntry_t entry;
        int idx;
        idx = pc >> 1;
        if ($isunknown(pc)) begin
            instr = nopWord;
        end else if (modelHalted) begin
            instr = writeProbeWord;  // Halted core must ignore it
        end else if (idx < (trapPhase ? trapProg.size() : prog.size())) begin
            entry = trapPhase ? trapProg[idx] : prog[idx];
            if (entry.skip) begin
                $display("Error at %0t: pc %h fetched an entry that should be jumped over",
                         $time, pc);
                otherErrors++;
            end
            instr = entry.instr;
        end else begin
            instr = haltWord;
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        instr = writeProbeWord;  // Enables must stay low in reset
        repeat (8) begin
            @(posedge clk);
            #1;
            checkWord("pc", 16'h0000, pc);
            checkWord("regWrtEn", 16'h0, {15'b0, regWrtEn});
            checkWord("memWrtEn", 16'h0, {15'b0, memWrtEn});
            checkWord("halted", 16'h0, {15'b0, halted});
            checkWord("err", 16'h0, {15'b0, err});
        end
        rstN = 1'b1;
    endtask

    task automatic runProgram();
        int holdCycles;
        bit first;
        modelPc = 16'h0000;
        modelHalted = 1'b0;
        modelErr = 1'b0;
        holdCycles = 0;
        first = 1'b1;
        while (holdCycles < 3) begin
            if (!first) begin
                @(posedge clk);
                #1;
                commitModel();
            end
            first = 1'b0;
            fetchInstr();
            checkWord("pc", modelPc, pc);
            computeExpected(instr);
            #5;
            checkWord("regWrtEn", {15'b0, expRegEn}, {15'b0, regWrtEn});
            if (expRegEn) begin
                checkWord("regWrtAddr", {13'b0, expRegAddr}, {13'b0, regWrtAddr});
                checkWord("regWrtData", expRegData, regWrtData);
            end
            checkWord("memWrtEn", {15'b0, expMemEn}, {15'b0, memWrtEn});
            if (expMemEn) begin
                checkWord("memAddr", expMemAddr, memAddr);
                checkWord("memWrtData", expMemData, memWrtData);
            end
            checkWord("halted", {15'b0, modelHalted}, {15'b0, halted});
            checkWord("err", {15'b0, modelErr}, {15'b0, err});
            if (modelHalted) begin
                holdCycles++;
            end
        end
    endtask

    initial begin
        int idx;
        clk = 1'b0;
        rstN = 1'b0;
        instr = nopWord;
        trapPhase = 1'b0;
        mismatches = 0;
        otherErrors = 0;
        cycleCount = 0;
        cycleLimit = 1000;
        seed = 32'h9e291806;

        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            addEntry(encI2(5'd24, regAddr_t'(k), rnd[7:0]), 1'b0);  // LBI
        end
        for (int k = 1; k < 3; k++) begin
            rnd = $random(seed);
            addEntry(encI2(5'd18, regAddr_t'(k), rnd[7:0]), 1'b0);  // SLBI
        end
        addEntry(encI1(5'd8, 3'd0, 3'd4, 5'b10110), 1'b0);
        addEntry(encI1(5'd9, 3'd1, 3'd5, 5'b00111), 1'b0);
        addEntry(encI1(5'd10, 3'd2, 3'd6, 5'b11001), 1'b0);
        addEntry(encI1(5'd11, 3'd3, 3'd7, 5'b10011), 1'b0);
        for (int f = 0; f < 4; f++) begin
            addEntry(encR(5'd27, regAddr_t'(f), regAddr_t'(f + 1), regAddr_t'(f + 2),
                          2'(f)), 1'b0);
            addEntry(encR(5'd28 + 5'(f), 3'd1, 3'd2, 3'd6, 2'd0), 1'b0);
        end
        addEntry(encR(5'd28, 3'd3, 3'd3, 3'd6, 2'd0), 1'b0);  // Equal operands
        addEntry(encR(5'd30, 3'd4, 3'd4, 3'd7, 2'd0), 1'b0);
        for (int f = 0; f < 4; f++) begin
            rnd = $random(seed);
            addEntry(encI1(5'd20 + 5'(f), regAddr_t'(f), regAddr_t'(f + 2), rnd[4:0]), 1'b0);
            addEntry(encR(5'd26, regAddr_t'(f + 1), regAddr_t'(f), regAddr_t'(5 - f),
                          2'(f)), 1'b0);
        end
        addEntry(encR(5'd25, 3'd2, 3'd0, 3'd4, 2'd0), 1'b0);  // BTR
        addEntry(encI1(5'd16, 3'd0, 3'd1, 5'd4), 1'b0);  // ST
        addEntry(encI1(5'd19, 3'd2, 3'd3, 5'b11110), 1'b0);  // STU
        addEntry(encI1(5'd17, 3'd0, 3'd4, 5'd4), 1'b0);
        addEntry(encI1(5'd17, 3'd2, 3'd5, 5'd0), 1'b0);  // Through updated base
        addEntry(encI2(5'd24, 3'd6, 8'h00), 1'b0);
        addEntry(encI2(5'd12, 3'd6, 8'd2), 1'b0);
        addEntry(encI1(5'd8, 3'd0, 3'd0, 5'd1), 1'b1);
        addEntry(encI2(5'd13, 3'd6, 8'd2), 1'b0);
        addEntry(encI2(5'd14, 3'd6, 8'd2), 1'b0);
        addEntry(encI2(5'd15, 3'd6, 8'd2), 1'b0);
        addEntry(encI1(5'd8, 3'd0, 3'd0, 5'd1), 1'b1);
        addEntry(encI2(5'd24, 3'd6, 8'hff), 1'b0);
        addEntry(encI2(5'd14, 3'd6, 8'd2), 1'b0);
        addEntry(encI1(5'd8, 3'd0, 3'd0, 5'd1), 1'b1);
        addEntry(encI2(5'd15, 3'd6, 8'd2), 1'b0);
        addEntry(encI2(5'd12, 3'd6, 8'd2), 1'b0);
        addEntry(encI2(5'd13, 3'd6, 8'd2), 1'b0);
        addEntry(encI1(5'd8, 3'd0, 3'd0, 5'd1), 1'b1);
        addEntry({5'd4, 11'd2}, 1'b0);  // J over one slot
        addEntry(encI1(5'd8, 3'd0, 3'd0, 5'd1), 1'b1);
        addEntry({5'd6, 11'd0}, 1'b0);  // JAL
        for (int op = 5; op < 8; op += 2) begin
            idx = prog.size();
            addEntry(encI2(5'd24, 3'd6, 8'(2 * (idx + 1))), 1'b0);
            addEntry(encI2(5'(op), 3'd6, 8'd4), 1'b0);  // JR, JALR
            addEntry(encI1(5'd8, 3'd0, 3'd0, 5'd1), 1'b1);
        end
        addEntry(haltWord, 1'b0);
        addEntry(nopWord, 1'b1);
        addEntry(nopWord, 1'b1);

        trapProg.push_back('{instr: nopWord, skip: 1'b0});
        trapProg.push_back('{instr: 16'h1000, skip: 1'b0});  // Opcode 00010
        trapProg.push_back('{instr: nopWord, skip: 1'b1});

        cycleLimit = 4 * (prog.size() + trapProg.size()) + 50;

        applyReset();
        runProgram();
        trapPhase = 1'b1;
        applyReset();
        runProgram();

        $display("Checks done with %0d mismatches and %0d other errors",
                 mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
design/wiscPkg.sv
design/control.sv
design/regFile.sv
design/alu.sv
design/branchUnit.sv
design/dataMem.sv
design/wiscCore.sv
verification/wiscCoreTb.sv
